// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_bus_bridge
FILELIST  := sources.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// File: sources.f
src/bridge_pkg.sv
src/bus_converter.sv
src/byte_arbiter.sv
src/byte_ram.sv
src/bus_bridge_top.sv
testbench/tb_bus_bridge.sv

// File: src/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    localparam int mem_aw      = 14;                       // Byte address width of the RAM
    localparam int word_aw     = mem_aw - 1;               // Word address width on the bus
    localparam int queue_depth = 2;                        // Request entries per converter
    localparam int queue_ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1; // Queue index
    localparam int queue_cnt_w = $clog2(queue_depth + 1);  // Fill level, 0 to queue_depth

    // One 16-bit bus request from a requester
    typedef struct packed {
        logic               valid;    // Request strobe, one cycle per request
        logic               we;       // Write when set, read when clear
        logic [word_aw-1:0] addr;     // Word address
        logic [1:0]         bytesel;  // Bit 0 low byte, bit 1 high byte
        logic [15:0]        wdata;    // Write data
    } bus_req_t;

    // Completion for reads and writes alike
    typedef struct packed {
        logic        valid;  // Completion strobe
        logic [15:0] rdata;  // Read data, unselected lanes zero
    } bus_rsp_t;

    // Single byte access toward the RAM
    typedef struct packed {
        logic              valid;  // Access strobe
        logic              we;     // Write when set
        logic [mem_aw-1:0] addr;   // Byte address, LSB picks odd/even byte
        logic [7:0]        wdata;  // Write byte
    } byte_req_t;

endpackage

`default_nettype wire

// File: src/bus_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module bus_bridge_top
    import bridge_pkg::*;
(
    input  logic     clk,       // System clock
    input  logic     rst,       // Async reset, active high
    input  bus_req_t req_a,     // Port a request
    input  bus_req_t req_b,     // Port b request
    output bus_rsp_t rsp_a,     // Port a completion
    output bus_rsp_t rsp_b,     // Port b completion
    output logic     credit_a,  // Port a credit return
    output logic     credit_b   // Port b credit return
);

    byte_req_t  breq_a;     // Converter a to arbiter
    byte_req_t  breq_b;     // Converter b to arbiter
    byte_req_t  mem_req;    // Arbiter to RAM
    logic       grant_a;
    logic       grant_b;
    logic       rdv_a;      // Read byte tag for port a
    logic       rdv_b;      // Read byte tag for port b
    logic [7:0] mem_rdata;  // Shared by both converters

    bus_converter conv_a (
        .clk         (clk),
        .rst         (rst),
        .req         (req_a),
        .rsp         (rsp_a),
        .credit      (credit_a),
        .mem_req     (breq_a),
        .grant       (grant_a),
        .rdata       (mem_rdata),
        .rdata_valid (rdv_a)
    );

    bus_converter conv_b (
        .clk         (clk),
        .rst         (rst),
        .req         (req_b),
        .rsp         (rsp_b),
        .credit      (credit_b),
        .mem_req     (breq_b),
        .grant       (grant_b),
        .rdata       (mem_rdata),
        .rdata_valid (rdv_b)
    );

    byte_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .req_a         (breq_a),
        .req_b         (breq_b),
        .grant_a       (grant_a),
        .grant_b       (grant_b),
        .mem_req       (mem_req),
        .mem_rdata     (mem_rdata),
        .rdata_valid_a (rdv_a),
        .rdata_valid_b (rdv_b)
    );

    byte_ram u_ram (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

endmodule

`default_nettype wire

// File: src/bus_converter.sv
`timescale 1ns/100ps
`default_nettype none

module bus_converter
    import bridge_pkg::*;
(
    input  logic      clk,          // System clock
    input  logic      rst,          // Active-high asynchronous reset
    input  bus_req_t  req,          // Request from the port's requester
    output bus_rsp_t  rsp,          // Completion back to the requester
    output logic      credit,       // Returns one queue entry
    output byte_req_t mem_req,      // Byte access toward the arbiter
    input  logic      grant,        // Arbiter accepts mem_req this cycle
    input  logic [7:0] rdata,       // Shared RAM read byte
    input  logic      rdata_valid   // rdata belongs to this port
);

    typedef enum logic [2:0] {
        s_idle,
        s_low,
        s_high,
        s_wait,
        s_done
    } state_t;

    bus_req_t               queue_mem [queue_depth];  // Request storage
    logic [queue_ptr_w-1:0] wr_ptr;                   // Next free slot
    logic [queue_ptr_w-1:0] rd_ptr;                   // Head slot
    logic [queue_cnt_w-1:0] count;                    // Entries held
    bus_req_t               head;                     // Request being worked on
    logic                   head_valid;               // Queue not empty
    logic                   push;
    logic                   pop;
    state_t                 state;                    // Registered FSM state
    state_t                 cur;                      // Effective state this cycle
    state_t                 state_nxt;
    logic                   lane_hi;                  // Outstanding read is the high byte
    logic [15:0]            rdata_q;                  // Collected read bytes

    function automatic logic [queue_ptr_w-1:0] ptr_inc(input logic [queue_ptr_w-1:0] p);
        return (p == queue_ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1; // Wrap at depth
    endfunction

    assign push       = req.valid;
    assign head       = queue_mem[rd_ptr];
    assign head_valid = (count != '0);
    assign pop        = (cur == s_done);  // Entry freed with the response

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Idle looks straight through to the first step of a waiting request
    always_comb begin
        cur = state;
        if (state == s_idle) begin
            if (!head_valid) begin
                cur = s_idle;
            end else if (head.bytesel[0]) begin
                cur = s_low;   // Low byte always goes first
            end else if (head.bytesel[1]) begin
                cur = s_high;
            end else begin
                cur = s_done;  // Nothing selected so answer at once
            end
        end
    end

    always_comb begin
        state_nxt = cur;  // Hold while not granted
        mem_req   = '0;
        case (cur)
            s_low: begin
                mem_req.valid = 1'b1;
                mem_req.we    = head.we;
                mem_req.addr  = {head.addr, 1'b0};  // Even byte
                mem_req.wdata = head.wdata[7:0];
                if (grant) begin
                    if (!head.we) begin
                        state_nxt = s_wait;
                    end else if (head.bytesel[1]) begin
                        state_nxt = s_high;
                    end else begin
                        state_nxt = s_done;
                    end
                end
            end
            s_high: begin
                mem_req.valid = 1'b1;
                mem_req.we    = head.we;
                mem_req.addr  = {head.addr, 1'b1};  // Odd byte
                mem_req.wdata = head.wdata[15:8];
                if (grant) begin
                    state_nxt = head.we ? s_done : s_wait;
                end
            end
            s_wait: begin
                if (rdata_valid) begin
                    state_nxt = (!lane_hi && head.bytesel[1]) ? s_high : s_done;
                end
            end
            s_done: state_nxt = s_idle;
            default: state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= s_idle;
            lane_hi <= 1'b0;
            rdata_q <= '0;
        end else begin
            state <= state_nxt;
            if (grant && mem_req.valid && !mem_req.we) begin
                lane_hi <= (cur == s_high);  // Remember which lane the read fills
            end
            if (cur == s_done) begin
                rdata_q <= '0;  // Clean slate for the next request
            end else if (cur == s_wait && rdata_valid) begin
                if (lane_hi) begin
                    rdata_q[15:8] <= rdata;
                end else begin
                    rdata_q[7:0] <= rdata;
                end
            end
        end
    end

    assign rsp.valid = (cur == s_done);
    assign rsp.rdata = rsp.valid ? rdata_q : '0;  // Writes and empty selects give zero
    assign credit    = rsp.valid;

    // Requester must never send without a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (count < queue_depth) || pop);

    // Read data only comes back for a read this port got granted
    a_rdata_after_read: assert property (@(posedge clk) disable iff (rst)
        rdata_valid |-> $past(grant && mem_req.valid && !mem_req.we));

endmodule

`default_nettype wire

// File: src/byte_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module byte_arbiter
    import bridge_pkg::*;
(
    input  logic       clk,            // System clock
    input  logic       rst,            // Async reset, active high
    input  byte_req_t  req_a,          // Byte access from port a
    input  byte_req_t  req_b,          // Byte access from port b
    output logic       grant_a,
    output logic       grant_b,
    output byte_req_t  mem_req,        // Winning access to the RAM
    input  logic [7:0] mem_rdata,      // RAM read byte, one cycle after the read
    output logic       rdata_valid_a,  // mem_rdata is for port a
    output logic       rdata_valid_b   // mem_rdata is for port b
);

    logic last_b;  // Port b won the last grant

    // Contention goes to whoever did not win last time
    assign grant_a = req_a.valid && (!req_b.valid || last_b);
    assign grant_b = req_b.valid && (!req_a.valid || !last_b);

    always_comb begin
        if (grant_a) begin
            mem_req = req_a;
        end else if (grant_b) begin
            mem_req = req_b;
        end else begin
            mem_req = '0;  // Idle RAM cycle
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_b        <= 1'b0;
            rdata_valid_a <= 1'b0;
            rdata_valid_b <= 1'b0;
        end else begin
            if (grant_a || grant_b) begin
                last_b <= grant_b;
            end
            rdata_valid_a <= grant_a && !req_a.we;  // Tag next cycle's read byte
            rdata_valid_b <= grant_b && !req_b.we;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(grant_a && grant_b));

    // RAM read bus rests at zero unless it carries a byte for a port
    a_rdata_idle_zero: assert property (@(posedge clk) disable iff (rst)
        !(rdata_valid_a || rdata_valid_b) |-> (mem_rdata == '0));

endmodule

`default_nettype wire

// File: src/byte_ram.sv
`timescale 1ns/100ps
`default_nettype none

module byte_ram
    import bridge_pkg::*;
(
    input  logic       clk,      // System clock
    input  byte_req_t  mem_req,  // Granted byte access
    output logic [7:0] rdata     // Registered read byte
);

    logic [7:0] mem [2**mem_aw];  // Byte array, contents kept across reset

    always_ff @(posedge clk) begin
        if (mem_req.valid && mem_req.we) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    // Read byte shows for one cycle, zero otherwise
    always_ff @(posedge clk) begin
        if (mem_req.valid && !mem_req.we) begin
            rdata <= mem[mem_req.addr];
        end else begin
            rdata <= '0;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_bus_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_bus_bridge
    import bridge_pkg::*;
();

    localparam int     clk_period  = 8;
    localparam int     rand_count  = 300;  // Random requests per port
    localparam int     fixed_count = 40;   // Upper bound on directed requests
    localparam int     worst_lat   = 12;   // Two-byte read plus waits behind the other port
    localparam int     margin      = 4;
    localparam longint timeout_ns  =
        longint'(2 * rand_count + fixed_count) * worst_lat * margin * clk_period + 1000;
    localparam logic [word_aw-1:0] base_a = word_aw'(13'h0100);  // Lower half only
    localparam logic [word_aw-1:0] base_b = word_aw'(13'h1100);  // Upper half only

    logic     clk;
    logic     rst;
    bus_req_t req_a;
    bus_req_t req_b;
    bus_rsp_t rsp_a;
    bus_rsp_t rsp_b;
    logic     credit_a;
    logic     credit_b;

    logic [31:0] lfsr = 32'd95605;       // Fibonacci LFSR state
    logic [7:0]  shadow [2**mem_aw];     // Byte-wise model of the RAM
    bit          known  [2**mem_aw];     // Byte has been written
    logic [15:0] exp_a [$];              // Expected rdata, port a
    logic [15:0] exp_b [$];              // Expected rdata, port b
    int          cred [2];               // Credits held per port
    int          sent [2];
    int          got  [2];               // Credit pulses seen
    int          errors       = 0;
    int          checks       = 0;
    int          tests_failed = 0;

    bus_bridge_top dut (
        .clk      (clk),
        .rst      (rst),
        .req_a    (req_a),
        .req_b    (req_b),
        .rsp_a    (rsp_a),
        .rsp_b    (rsp_b),
        .credit_a (credit_a),
        .credit_b (credit_b)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog expired at %0t, responses stopped coming back", $time);
        $display("TEST FAILED");
        $finish;
    end

    // Taps 32, 22, 2, 1; one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic bus_req_t make_req(input logic we, input logic [word_aw-1:0] addr,
                                          input logic [1:0] sel, input logic [15:0] wd);
        bus_req_t r;
        r.valid   = 1'b1;
        r.we      = we;
        r.addr    = addr;
        r.bytesel = sel;
        r.wdata   = wd;
        return r;
    endfunction

    function automatic logic [word_aw-1:0] word_of(input int p, input int off);
        return (p == 0 ? base_a : base_b) + word_aw'(off);
    endfunction

    // Low lane at even byte, high lane at odd byte; unselected read lanes stay zero
    function automatic logic [15:0] predict(input bus_req_t r);
        logic [mem_aw-1:0] lo;
        logic [mem_aw-1:0] hi;
        logic [15:0]       res;
        lo  = {r.addr, 1'b0};
        hi  = {r.addr, 1'b1};
        res = '0;
        if (r.we) begin
            if (r.bytesel[0]) begin
                shadow[lo] = r.wdata[7:0];
                known[lo]  = 1'b1;
            end
            if (r.bytesel[1]) begin
                shadow[hi] = r.wdata[15:8];
                known[hi]  = 1'b1;
            end
        end else begin
            if (r.bytesel[0]) res[7:0]  = shadow[lo];
            if (r.bytesel[1]) res[15:8] = shadow[hi];
        end
        return res;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic observe(input int p, input bus_rsp_t rsp, input logic credit);
        logic [15:0] e;
        check_val(p == 0 ? "credit_a" : "credit_b", rsp.valid, credit);  // Same cycle as rsp
        if (credit) begin
            cred[p]++;
            got[p]++;
            if (cred[p] > queue_depth) begin
                errors++;
                $display("Port %0d got back more credits than it spent at %0t", p, $time);
            end
        end
        if (rsp.valid) begin
            if ((p == 0 ? exp_a.size() : exp_b.size()) == 0) begin
                errors++;
                $display("Port %0d answered with no request outstanding at %0t", p, $time);
            end else begin
                e = (p == 0) ? exp_a.pop_front() : exp_b.pop_front();
                check_val(p == 0 ? "rsp_a.rdata" : "rsp_b.rdata", e, rsp.rdata);
            end
        end
    endtask

    // Next falling edge, sample responses, clear strobes
    task automatic tick();
        @(negedge clk);
        req_a = '0;
        req_b = '0;
        observe(0, rsp_a, credit_a);
        observe(1, rsp_b, credit_b);
    endtask

    task automatic drive_port(input int p, input bus_req_t r);
        logic [15:0] e;
        e = predict(r);
        if (cred[p] == 0) begin
            errors++;
            $display("Port %0d sent a request without a credit at %0t", p, $time);
        end
        cred[p]--;
        sent[p]++;
        if (p == 0) begin
            exp_a.push_back(e);
            req_a = r;
        end else begin
            exp_b.push_back(e);
            req_b = r;
        end
        if ((p == 0 ? exp_a.size() : exp_b.size()) > queue_depth) begin
            errors++;
            $display("Port %0d has more than %0d requests outstanding", p, queue_depth);
        end
    endtask

    task automatic send(input int p, input bus_req_t r);
        tick();
        while (cred[p] == 0) tick();
        drive_port(p, r);
    endtask

    task automatic drain();
        while (exp_a.size() != 0 || exp_b.size() != 0) tick();
    endtask

    // Reads of never-written bytes turn into full writes
    function automatic bus_req_t random_req(input int p);
        bus_req_t r;
        r = make_req(rand_bits(1), word_of(p, rand_bits(5)), rand_bits(2), rand_bits(16));
        if (!r.we && ((r.bytesel[0] && !known[{r.addr, 1'b0}]) ||
                      (r.bytesel[1] && !known[{r.addr, 1'b1}]))) begin
            r.we      = 1'b1;
            r.bytesel = 2'b11;
        end
        return r;
    endfunction

    task automatic end_test(input int n, input string name, input int err0);
        if (errors == err0) begin
            $display("test %0d %s: passed", n, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", n, name, errors - err0);
        end
    endtask

    initial begin
        int err0;
        int p;
        int left [2];
        int sent0 [2];
        int got0 [2];
        rst     = 1'b1;
        req_a   = '0;
        req_b   = '0;
        cred[0] = queue_depth;
        cred[1] = queue_depth;
        sent    = '{0, 0};
        got     = '{0, 0};
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        err0 = errors;
        repeat (20) begin
            tick();
            check_val("rsp_a.valid", 0, rsp_a.valid);
            check_val("rsp_b.valid", 0, rsp_b.valid);
        end
        end_test(1, "quiet after reset", err0);

        err0 = errors;
        for (p = 0; p < 2; p++) begin
            send(p, make_req(1'b1, word_of(p, 0), 2'b11, 16'hC3A5 ^ 16'(p)));
            send(p, make_req(1'b0, word_of(p, 0), 2'b11, 16'h0000));
        end
        drain();
        end_test(2, "word write then read", err0);

        err0 = errors;
        for (p = 0; p < 2; p++) begin
            send(p, make_req(1'b1, word_of(p, 1), 2'b11, 16'h1234));
            send(p, make_req(1'b1, word_of(p, 1), 2'b01, 16'hFFAB));  // High byte ignored
            send(p, make_req(1'b0, word_of(p, 1), 2'b11, 16'h0000));
            send(p, make_req(1'b0, word_of(p, 1), 2'b10, 16'h0000));  // Low lane reads zero
        end
        drain();
        end_test(3, "single byte lanes", err0);

        err0 = errors;
        for (p = 0; p < 2; p++) begin
            send(p, make_req(1'b1, word_of(p, 2), 2'b11, 16'h5A5A));
            send(p, make_req(1'b1, word_of(p, 2), 2'b00, 16'hFFFF));  // Must not land
            send(p, make_req(1'b0, word_of(p, 2), 2'b00, 16'h0000));
            send(p, make_req(1'b0, word_of(p, 2), 2'b11, 16'h0000));
        end
        drain();
        end_test(4, "empty byte select", err0);

        err0 = errors;
        for (p = 0; p < 2; p++) begin
            left[p]  = rand_count;
            sent0[p] = sent[p];
            got0[p]  = got[p];
        end
        while (left[0] > 0 || left[1] > 0) begin
            tick();
            for (p = 0; p < 2; p++) begin
                if (left[p] > 0 && cred[p] > 0) begin
                    if (rand_bits(1)) begin
                        drive_port(p, random_req(p));
                        left[p]--;
                    end
                end
            end
        end
        drain();
        check_val("credit_a count", sent[0] - sent0[0], got[0] - got0[0]);
        check_val("credit_b count", sent[1] - sent0[1], got[1] - got0[1]);
        end_test(5, "random traffic on both ports", err0);

        $display("Tests run 5, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
